// ==== src.f ====
hdl/ldpc_enc_pkg.sv
hdl/ldpc_enc_buf_if.sv
hdl/ldpc_enc_source.sv
hdl/ldpc_enc_buffer.sv
hdl/ldpc_enc_sink.sv
hdl/ldpc_enc.sv
dv/ldpc_enc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ldpc encoder testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module ldpc_enc_tb \
  -o ldpc_enc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/ldpc_enc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
exit 1

// ==== dv/ldpc_enc_tb.sv ====
module ldpc_enc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ldpc_enc_pkg::*;

  typedef logic [cK-1:0][cZ-1:0] frame_t;  // four data words
  typedef logic [cN-1:0][cZ-1:0] cword_t;  // data then parity

  localparam int n_frames = 43;  // 1 + 20 + 20 + 2

  logic iclk, rst, isop, ival, ieop, ireq;
  dat_t idat;
  tag_t itag;
  logic ordy, obusy, ofull, osop, oval, oeop;
  dat_t odat;
  tag_t otag;

  logic [cTAG_W+cZ+1:0] exp_q [$];  // {tag, sop, eop, word}
  frame_t saved_d [20];             // replayed under back-pressure
  tag_t   saved_t [20];
  integer seed = 37;
  int     req_mode = 0;             // 0 low, 1 high, 2 random
  int     errors = 0;
  int     err_mark = 0;
  int     out_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;

  ldpc_enc u_dut (
    .iclk (iclk), .rst (rst), .isop (isop), .ival (ival), .ieop (ieop),
    .idat (idat), .itag (itag), .ordy (ordy), .obusy (obusy), .ireq (ireq),
    .ofull (ofull), .osop (osop), .oval (oval), .oeop (oeop), .odat (odat),
    .otag (otag)
  );

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;  // 40 ns period
  end

  // --------------------
  // reference encoder
  // --------------------

  // parity j = xor of data word i rotated left by cSHIFT[j][i]
  function automatic cword_t encode_ref(input frame_t d);
    cword_t cw;
    dat_t   p;
    int     sh;
    for (int i = 0; i < cK; i++) cw[i] = d[i];
    for (int j = 0; j < cM; j++) begin
      p = '0;
      for (int i = 0; i < cK; i++) begin
        if (cSHIFT[j][i] != cNO_SHIFT) begin
          sh = int'(cSHIFT[j][i]);
          for (int b = 0; b < cZ; b++) p[(b + sh) % cZ] ^= d[i][b];  // bit b to b+sh
        end
      end
      cw[cK+j] = p;
    end
    return cw;
  endfunction

  // --------------------
  // stimulus helpers
  // --------------------

  task automatic new_frame(output frame_t d, output tag_t t);
    for (int i = 0; i < cK; i++) d[i] = dat_t'($random(seed));
    t = tag_t'($random(seed));
  endtask

  task automatic send_frame(input frame_t d, input tag_t t);
    cword_t cw;
    cw = encode_ref(d);
    for (int k = 0; k < cN; k++) exp_q.push_back({t, (k == 0), (k == cN - 1), cw[k]});
    do @(negedge iclk); while (!ordy);  // idle with room, stays ready
    for (int i = 0; i < cK; i++) begin
      @(posedge iclk);
      ival <= 1'b1;
      isop <= (i == 0);
      ieop <= (i == cK - 1);
      idat <= d[i];
      itag <= t;
    end
    @(posedge iclk);
    ival <= 1'b0;
    isop <= 1'b0;
    ieop <= 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < limit)) begin
      @(negedge iclk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("output stalled at %0t with %0d words still expected", $time, exp_q.size());
      errors++;
      exp_q.delete();
    end
    repeat (4) @(negedge iclk);  // catch stray words
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // request pattern, one driver
  initial begin
    ireq = 1'b0;
    forever begin
      @(posedge iclk);
      case (req_mode)
        1:       ireq <= 1'b1;
        2:       ireq <= (($random(seed) % 2) != 0);
        default: ireq <= 1'b0;
      endcase
    end
  end

  // --------------------
  // compare
  // --------------------

  always @(posedge iclk) begin
    logic [cTAG_W+cZ+1:0] e;
    if (!rst && oval) begin
      out_cnt++;
      if (exp_q.size() == 0) begin
        $display("unexpected output word %h at %0t", odat, $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (odat !== e[cZ-1:0]) begin
          $display("FAIL %0t: odat %h, expected %h", $time, odat, e[cZ-1:0]);
          errors++;
        end
        if ((osop !== e[cZ+1]) || (oeop !== e[cZ])) begin
          $display("FAIL %0t: sop/eop %b%b, expected %b%b", $time, osop, oeop,
                   e[cZ+1], e[cZ]);
          errors++;
        end
        if (otag !== e[cTAG_W+cZ+1:cZ+2]) begin
          $display("FAIL %0t: otag %h, expected %h", $time, otag, e[cTAG_W+cZ+1:cZ+2]);
          errors++;
        end
      end
    end
  end

  initial begin
    #((n_frames * 40 + 500) * 40);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("** FAIL **");
    $finish;
  end

  // --------------------
  // test sequence
  // --------------------

  initial begin
    frame_t d;
    tag_t   t;
    int     n;
    rst  = 1'b1;
    isop = 1'b0;
    ival = 1'b0;
    ieop = 1'b0;
    idat = '0;
    itag = '0;
    repeat (3) @(posedge iclk);
    rst <= 1'b0;

    @(negedge iclk);
    if ((ordy !== 1'b1) || (obusy !== 1'b0) || (ofull !== 1'b0) || (oval !== 1'b0)) begin
      $display("FAIL %0t: reset state ordy %b obusy %b ofull %b oval %b", $time,
               ordy, obusy, ofull, oval);
      errors++;
    end
    end_test("reset");

    req_mode = 1;
    new_frame(d, t);
    send_frame(d, t);
    wait_drain(40);
    end_test("single frame");

    out_cnt = 0;
    for (int f = 0; f < 20; f++) begin
      new_frame(saved_d[f], saved_t[f]);
      send_frame(saved_d[f], saved_t[f]);
    end
    wait_drain(20 * 40);
    if (out_cnt != 20 * cN) begin
      $display("back to back run gave %0d words instead of %0d", out_cnt, 20 * cN);
      errors++;
    end
    end_test("back to back");

    req_mode = 2;  // same frames, random ireq
    out_cnt  = 0;
    for (int f = 0; f < 20; f++) send_frame(saved_d[f], saved_t[f]);
    wait_drain(20 * 40);
    if (out_cnt != 20 * cN) begin
      $display("back-pressure run gave %0d words instead of %0d", out_cnt, 20 * cN);
      errors++;
    end
    end_test("back-pressure");

    req_mode = 0;  // both banks fill up
    for (int f = 0; f < 2; f++) begin
      new_frame(d, t);
      send_frame(d, t);
    end
    n = 0;
    while (obusy && (n < 20)) begin
      @(negedge iclk);
      n++;
    end
    repeat (8) begin
      @(negedge iclk);
      if ((ofull !== 1'b1) || (ordy !== 1'b0)) begin
        $display("FAIL %0t: banks full but ofull %b ordy %b", $time, ofull, ordy);
        errors++;
      end
    end
    req_mode = 1;
    wait_drain(80);
    if (ordy !== 1'b1) begin
      $display("FAIL %0t: ordy stays low after both banks drained", $time);
      errors++;
    end
    end_test("both banks full");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (errors == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== hdl/ldpc_enc.sv ====
module ldpc_enc (
  input  logic               iclk,
  input  logic               rst,
  input  logic               isop,
  input  logic               ival,
  input  logic               ieop,
  input  ldpc_enc_pkg::dat_t idat,
  input  ldpc_enc_pkg::tag_t itag,
  output logic               ordy,
  output logic               obusy,
  input  logic               ireq,
  output logic               ofull,
  output logic               osop,
  output logic               oval,
  output logic               oeop,
  output ldpc_enc_pkg::dat_t odat,
  output ldpc_enc_pkg::tag_t otag
);

  ldpc_enc_wr_if wr_if ();  // source -> buffer
  ldpc_enc_rd_if rd_if ();  // buffer -> sink

  // --------------------
  // encoder path
  // --------------------

  ldpc_enc_source u_source (
    .iclk  (iclk),
    .rst   (rst),
    .isop  (isop),
    .ival  (ival),
    .ieop  (ieop),
    .idat  (idat),
    .itag  (itag),
    .ordy  (ordy),
    .obusy (obusy),
    .wr    (wr_if)
  );

  ldpc_enc_buffer u_buffer (
    .iclk (iclk),
    .rst  (rst),
    .wr   (wr_if),
    .rd   (rd_if)
  );

  ldpc_enc_sink u_sink (
    .iclk  (iclk),
    .rst   (rst),
    .ireq  (ireq),
    .ofull (ofull),
    .osop  (osop),
    .oval  (oval),
    .oeop  (oeop),
    .odat  (odat),
    .otag  (otag),
    .rd    (rd_if)
  );

endmodule

// ==== hdl/ldpc_enc_sink.sv ====
module ldpc_enc_sink (
  input  logic               iclk,
  input  logic               rst,
  input  logic               ireq,
  output logic               ofull,
  output logic               osop,
  output logic               oval,
  output logic               oeop,
  output ldpc_enc_pkg::dat_t odat,
  output ldpc_enc_pkg::tag_t otag,
  ldpc_enc_rd_if.snk         rd
);
  import ldpc_enc_pkg::*;

  snk_state_t state;
  addr_t      cnt;    // word being read
  logic       issue;  // address goes out this cycle
  logic       first;
  logic       last;

  assign issue = ireq && ((state == snk_read) || rd.full);
  assign first = (cnt == '0);
  assign last  = (cnt == addr_t'(cN - 1));

  assign rd.raddr  = cnt;
  assign rd.rempty = issue && last;  // bank free after word 5
  assign ofull     = rd.full;

  // --------------------
  // read sequencer
  // --------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      state <= snk_idle;
      cnt   <= '0;
    end else if (issue) begin
      state <= last ? snk_idle : snk_read;
      cnt   <= last ? '0 : cnt + 1'b1;
    end
  end

  // align flags with registered rdat
  always_ff @(posedge iclk) begin
    if (rst) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
    end else begin
      oval <= issue;
      osop <= issue && first;
      oeop <= issue && last;
    end
  end

  always_ff @(posedge iclk) begin
    if (issue && first) begin
      otag <= rd.rtag;  // held for the whole codeword
    end
  end

  assign odat = rd.rdat;

  // every output word came from a read of a full bank
  a_val_after_read : assert property (@(posedge iclk) disable iff (rst)
    oval |-> $past(rd.full));

endmodule

// ==== hdl/ldpc_enc_buffer.sv ====
module ldpc_enc_buffer (
  input  logic        iclk,
  input  logic        rst,
  ldpc_enc_wr_if.buff wr,
  ldpc_enc_rd_if.buff rd
);
  import ldpc_enc_pkg::*;

  dat_t       mem      [2][cN];  // two codeword banks
  tag_t       bank_tag [2];
  logic [1:0] bank_full;         // one flag per bank
  logic       wbank;             // bank the source fills
  logic       rbank;             // bank the sink drains

  // --------------------
  // status
  // --------------------

  assign wr.ready = !bank_full[wbank];
  assign rd.full  = bank_full[rbank];
  assign rd.rtag  = bank_tag[rbank];

  always_ff @(posedge iclk) begin
    if (rst) begin
      bank_full <= '0;
      wbank     <= 1'b0;
      rbank     <= 1'b0;
    end else begin
      if (wr.wfull) begin
        bank_full[wbank] <= 1'b1;  // seen by the sink next cycle
        wbank            <= ~wbank;
      end
      if (rd.rempty) begin
        bank_full[rbank] <= 1'b0;
        rbank            <= ~rbank;
      end
    end
  end

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge iclk) begin
    if (wr.write) begin
      mem[wbank][wr.waddr] <= wr.wdat;
    end
    if (wr.write && (wr.waddr == '0)) begin
      bank_tag[wbank] <= wr.wtag;  // tag rides with word 0
    end
  end

  // registered read, one clock latency
  always_ff @(posedge iclk) begin
    rd.rdat <= mem[rbank][rd.raddr];
  end

  // source must respect ready
  a_no_wr_full : assert property (@(posedge iclk) disable iff (rst)
    wr.write |-> !bank_full[wbank]);

  // sink only releases what it holds
  a_no_rempty_empty : assert property (@(posedge iclk) disable iff (rst)
    rd.rempty |-> bank_full[rbank]);

endmodule

// ==== hdl/ldpc_enc_source.sv ====
module ldpc_enc_source (
  input  logic               iclk,
  input  logic               rst,
  input  logic               isop,
  input  logic               ival,
  input  logic               ieop,
  input  ldpc_enc_pkg::dat_t idat,
  input  ldpc_enc_pkg::tag_t itag,
  output logic               ordy,
  output logic               obusy,
  ldpc_enc_wr_if.src         wr
);
  import ldpc_enc_pkg::*;

  src_state_t state;
  addr_t      cnt;            // index of the next data word
  dat_t       par     [cM];   // running parity
  dat_t       par_add [cM];   // this word's share of each parity
  logic       acc_sop;
  logic       acc_dat;

  // bit b goes to bit (b + s) mod cZ
  function automatic dat_t rotl(dat_t d, logic [2:0] s);
    dat_t r;
    r = (d << s) | (d >> (cZ - int'(s)));
    return r;
  endfunction

  assign ordy    = ((state == src_idle) || (state == src_data)) && wr.ready;
  assign acc_sop = ival && ordy && isop && (state == src_idle);  // word 0
  assign acc_dat = ival && ordy && (state == src_data);          // words 1..3
  assign obusy   = (state != src_idle);

  // --------------------
  // parity accumulation
  // --------------------

  always_comb begin
    for (int j = 0; j < cM; j++) begin
      par_add[j] = '0;
      for (int i = 0; i < cK; i++) begin
        if ((cnt == addr_t'(i)) && (cSHIFT[j][i] != cNO_SHIFT)) begin
          par_add[j] = rotl(idat, cSHIFT[j][i][2:0]);
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    for (int j = 0; j < cM; j++) begin
      if (acc_sop) begin
        par[j] <= par_add[j];           // new frame drops old parity
      end else if (acc_dat) begin
        par[j] <= par[j] ^ par_add[j];
      end
    end
  end

  // --------------------
  // control
  // --------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      state <= src_idle;
      cnt   <= '0;
    end else begin
      case (state)
        src_idle: begin
          if (acc_sop) begin
            state <= src_data;
            cnt   <= cnt + 1'b1;
          end
        end
        src_data: begin
          if (acc_dat) begin
            cnt <= ieop ? '0 : cnt + 1'b1;
            if (ieop) state <= src_par0;
          end
        end
        src_par0: state <= src_par1;
        src_par1: state <= src_idle;
        default:  state <= src_idle;
      endcase
    end
  end

  // data words go straight through, parity from the registers
  always_comb begin
    wr.write = acc_sop || acc_dat;
    wr.waddr = cnt;
    wr.wdat  = idat;
    wr.wfull = 1'b0;
    case (state)
      src_par0: begin
        wr.write = 1'b1;
        wr.waddr = addr_t'(cK);
        wr.wdat  = par[0];
      end
      src_par1: begin
        wr.write = 1'b1;
        wr.waddr = addr_t'(cK + 1);
        wr.wdat  = par[1];
        wr.wfull = 1'b1;                // last word, hand bank over
      end
      default: ;
    endcase
  end

  assign wr.wtag = itag;  // buffer keeps it at address 0

  // frame length fixed at cK words
  a_eop_word3 : assert property (@(posedge iclk) disable iff (rst)
    (ival && ordy && ieop) |-> (state == src_data) && (cnt == addr_t'(cK - 1)));

  a_no_val_wo_rdy : assert property (@(posedge iclk) disable iff (rst)
    !(ival && !ordy));

endmodule

// ==== hdl/ldpc_enc_buf_if.sv ====
// write side, source into codeword buffer
interface ldpc_enc_wr_if;
  import ldpc_enc_pkg::*;

  logic  write;  // store wdat at waddr
  addr_t waddr;
  dat_t  wdat;
  tag_t  wtag;   // latched with address 0
  logic  wfull;  // closes the write bank
  logic  ready;  // write bank not full

  modport src  (output write, waddr, wdat, wtag, wfull, input ready);
  modport buff (input write, waddr, wdat, wtag, wfull, output ready);

endinterface

// read side, codeword buffer into sink
interface ldpc_enc_rd_if;
  import ldpc_enc_pkg::*;

  addr_t raddr;
  logic  rempty;  // releases the read bank
  logic  full;    // read bank holds a codeword
  dat_t  rdat;    // one clock after raddr
  tag_t  rtag;

  modport buff (input raddr, rempty, output full, rdat, rtag);
  modport snk  (output raddr, rempty, input full, rdat, rtag);

endinterface

// ==== hdl/ldpc_enc_pkg.sv ====
package ldpc_enc_pkg;

  // --------------------
  // code geometry
  // --------------------

  localparam int cZ      = 8;        // lifting size == data word width
  localparam int cK      = 4;        // systematic words per frame
  localparam int cM      = 2;        // parity words per frame
  localparam int cN      = cK + cM;  // words per codeword
  localparam int cTAG_W  = 4;
  localparam int cADDR_W = 3;        // word address inside one bank

  // --------------------
  // vector types
  // --------------------

  typedef logic [cZ-1:0]      dat_t;   // one lifted word
  typedef logic [cTAG_W-1:0]  tag_t;
  typedef logic [cADDR_W-1:0] addr_t;

  // --------------------
  // base matrix
  // --------------------

  // empty entry, outside the 0..7 shift range
  localparam logic [3:0] cNO_SHIFT = 4'd8;

  // rows are parity words, columns are data words
  // entry is the left rotation applied before the xor
  localparam logic [3:0] cSHIFT [0:cM-1][0:cK-1] = '{
    '{4'd0, 4'd3, cNO_SHIFT, 4'd5},  // parity 0
    '{4'd1, cNO_SHIFT, 4'd6, 4'd2}   // parity 1
  };

  // state machines
  typedef enum logic [1:0] {
    src_idle,  // waiting for sop
    src_data,  // words 1..3
    src_par0,  // parity 0 write
    src_par1   // parity 1 write, bank closes
  } src_state_t;

  typedef enum logic {
    snk_idle,
    snk_read
  } snk_state_t;

endpackage
